//--- src/fft_pkg.sv
`default_nettype none

package fft_pkg;

        // Q1.14 sample, 16384 is 1.0
        typedef logic signed [15:0] sample_t;

        typedef struct packed {
                sample_t re;
                sample_t im;
        } complex_t;

        // Butterfly operands and results share this layout
        typedef struct packed {
                complex_t a;
                complex_t b;
        } lane_pair_t;

        typedef logic [1:0] slot_t;

        localparam sample_t SAMPLE_ONE = 16'sd16384;

        // 0.7071 in Q1.14
        localparam sample_t TWIDDLE_HALF = 16'sd11585;

        // Product shift back to Q1.14
        localparam int FRAC_BITS = 14;

        // W(k) = exp(-j*pi*k/4)
        function automatic complex_t twiddle_lookup(input slot_t k);
                complex_t w;
                case (k)
                        2'd0:    w = '{re: SAMPLE_ONE, im: '0};
                        2'd1:    w = '{re: TWIDDLE_HALF, im: -TWIDDLE_HALF};
                        2'd2:    w = '{re: '0, im: -SAMPLE_ONE};
                        default: w = '{re: -TWIDDLE_HALF, im: -TWIDDLE_HALF};
                endcase
                return w;
        endfunction

endpackage

`default_nettype wire

//--- src/slot_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module slot_sequencer import fft_pkg::*;
(
        input  wire       clk,
        input  wire       reset,
        output slot_t     slot,
        output complex_t  twiddle,
        output logic      frame_done
);

        localparam slot_t LAST_SLOT = 2'd3;

        // Free-running, wraps every four cycles
        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        slot <= '0;
                end
                else
                begin
                        slot <= slot + 2'd1;
                end
        end

        assign twiddle = twiddle_lookup(slot);

        // High in the cycle after the slot 3 load
        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        frame_done <= 1'b0;
                end
                else
                begin
                        frame_done <= (slot == LAST_SLOT);
                end
        end

        // Slot steps by one every cycle out of reset
        assert property (@(posedge clk) disable iff (reset)
                $past(!reset) |-> slot == slot_t'($past(slot) + 2'd1));

        // Frame pulse is a single cycle and recurs four cycles later
        assert property (@(posedge clk) disable iff (reset)
                frame_done |=> !frame_done ##1 !frame_done ##1 !frame_done
                               ##1 frame_done);

endmodule

`default_nettype wire

//--- src/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select import fft_pkg::*;
#(
        parameter int LANE_SIZE = 8
)
(
        input  wire complex_t lane_in [LANE_SIZE],
        input  wire slot_t    slot,
        output lane_pair_t    pair
);

        localparam int HALF  = LANE_SIZE / 2;
        localparam int IDX_W = (LANE_SIZE > 1) ? $clog2(LANE_SIZE) : 1;

        logic [IDX_W-1:0] idx_a;
        logic [IDX_W-1:0] idx_b;

        // Partner sample sits half a lane further on
        assign idx_a = IDX_W'(slot);
        assign idx_b = IDX_W'(slot) + IDX_W'(HALF);

        always_comb
        begin
                pair.a = lane_in[idx_a];
                pair.b = lane_in[idx_b];
        end

endmodule

`default_nettype wire

//--- src/butterfly_unit.sv
`timescale 1ns/1ps
`default_nettype none

module butterfly_unit import fft_pkg::*;
(
        input  wire lane_pair_t operands,
        input  wire complex_t   twiddle,
        output lane_pair_t      result
);

        localparam int SAMPLE_W = $bits(sample_t);
        localparam int PROD_W   = 2 * SAMPLE_W;

        sample_t a_re;
        sample_t a_im;
        sample_t b_re;
        sample_t b_im;
        sample_t w_re;
        sample_t w_im;

        logic signed [PROD_W-1:0] rr;
        logic signed [PROD_W-1:0] ii;
        logic signed [PROD_W-1:0] ri;
        logic signed [PROD_W-1:0] ir;

        // One extra bit so the cross sums cannot overflow
        logic signed [PROD_W:0] prod_re;
        logic signed [PROD_W:0] prod_im;
        logic signed [PROD_W:0] scaled_re;
        logic signed [PROD_W:0] scaled_im;

        sample_t wb_re;
        sample_t wb_im;

        assign a_re = operands.a.re;
        assign a_im = operands.a.im;
        assign b_re = operands.b.re;
        assign b_im = operands.b.im;
        assign w_re = twiddle.re;
        assign w_im = twiddle.im;

        // Partial products at full width
        assign rr = b_re * w_re;
        assign ii = b_im * w_im;
        assign ri = b_re * w_im;
        assign ir = b_im * w_re;

        assign prod_re = rr - ii;
        assign prod_im = ri + ir;

        // Arithmetic shift rounds toward minus infinity
        assign scaled_re = prod_re >>> FRAC_BITS;
        assign scaled_im = prod_im >>> FRAC_BITS;

        assign wb_re = scaled_re[SAMPLE_W-1:0];
        assign wb_im = scaled_im[SAMPLE_W-1:0];

        // Sum and difference wrap at 16 bits
        always_comb
        begin
                result.a.re = a_re + wb_re;
                result.a.im = a_im + wb_im;
                result.b.re = a_re - wb_re;
                result.b.im = a_im - wb_im;
        end

endmodule

`default_nettype wire

//--- src/result_bank.sv
`timescale 1ns/1ps
`default_nettype none

module result_bank import fft_pkg::*;
#(
        parameter int  LANE_SIZE = 8,
        parameter type payload_t = complex_t
)
(
        input  wire           clk,
        input  wire           reset,
        input  wire slot_t    slot,
        input  wire payload_t upper,
        input  wire payload_t lower,
        output payload_t      lane_out [LANE_SIZE]
);

        localparam int HALF  = LANE_SIZE / 2;
        localparam int IDX_W = (LANE_SIZE > 1) ? $clog2(LANE_SIZE) : 1;

        logic [IDX_W-1:0] idx_upper;
        logic [IDX_W-1:0] idx_lower;

        assign idx_upper = IDX_W'(slot);
        assign idx_lower = IDX_W'(slot) + IDX_W'(HALF);

        // Two entries per edge, the rest hold
        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        for (int i = 0; i < LANE_SIZE; i++)
                        begin
                                lane_out[i] <= '0;
                        end
                end
                else
                begin
                        lane_out[idx_upper] <= upper;
                        lane_out[idx_lower] <= lower;
                end
        end

        // Both halves of the pair must land in distinct entries
        assert property (@(posedge clk) disable iff (reset)
                idx_upper != idx_lower);

endmodule

`default_nettype wire

//--- src/fft_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module fft_stage_top import fft_pkg::*;
#(
        parameter  int NUM_LANES = 4,
        localparam int LANE_SIZE = 8
)
(
        input  wire           clk,
        input  wire           reset,
        input  wire complex_t samples_in  [NUM_LANES*LANE_SIZE],
        output wire complex_t samples_out [NUM_LANES*LANE_SIZE],
        output wire           frame_done
);

        slot_t    slot;
        complex_t twiddle;

        // Slot and twiddle are shared by every lane
        slot_sequencer u_slot_sequencer (
                .clk        (clk),
                .reset      (reset),
                .slot       (slot),
                .twiddle    (twiddle),
                .frame_done (frame_done)
        );

        for (genvar lane = 0; lane < NUM_LANES; lane++)
        begin : g_lane
                localparam int BASE = lane * LANE_SIZE;

                lane_pair_t operands;
                lane_pair_t result;

                operand_select #(
                        .LANE_SIZE (LANE_SIZE)
                ) u_operand_select (
                        .lane_in (samples_in[BASE : BASE+LANE_SIZE-1]),
                        .slot    (slot),
                        .pair    (operands)
                );

                butterfly_unit u_butterfly_unit (
                        .operands (operands),
                        .twiddle  (twiddle),
                        .result   (result)
                );

                // a + Wb goes to offset k, a - Wb to offset k+4
                result_bank #(
                        .LANE_SIZE (LANE_SIZE),
                        .payload_t (complex_t)
                ) u_result_bank (
                        .clk      (clk),
                        .reset    (reset),
                        .slot     (slot),
                        .upper    (result.a),
                        .lower    (result.b),
                        .lane_out (samples_out[BASE : BASE+LANE_SIZE-1])
                );
        end

endmodule

`default_nettype wire

//--- bench/fft_model.svh
`ifndef FFT_MODEL_SVH
`define FFT_MODEL_SVH

// W(k) = exp(-j*pi*k/4) in Q1.14
function automatic complex_t model_twiddle(input int k);
        complex_t w;
        case (k % 4)
                0:       w = '{re: 16'sd16384, im: 16'sd0};
                1:       w = '{re: 16'sd11585, im: -16'sd11585};
                2:       w = '{re: 16'sd0, im: -16'sd16384};
                default: w = '{re: -16'sd11585, im: -16'sd11585};
        endcase
        return w;
endfunction

// Divide by 2^14, rounding toward minus infinity
function automatic longint floor_q14(input longint p);
        longint q;
        q = p / 16384;
        if ((p % 16384) != 0 && p < 0)
                q = q - 1;
        return q;
endfunction

function automatic lane_pair_t model_butterfly(input complex_t a, input complex_t b,
                                               input complex_t w);
        longint     prod_re;
        longint     prod_im;
        sample_t    wb_re;
        sample_t    wb_im;
        lane_pair_t r;
        prod_re = longint'(b.re) * longint'(w.re) - longint'(b.im) * longint'(w.im);
        prod_im = longint'(b.re) * longint'(w.im) + longint'(b.im) * longint'(w.re);
        wb_re = sample_t'(floor_q14(prod_re));
        wb_im = sample_t'(floor_q14(prod_im));
        // Keep only the low 16 bits of sum and difference
        r.a.re = sample_t'(longint'(a.re) + longint'(wb_re));
        r.a.im = sample_t'(longint'(a.im) + longint'(wb_im));
        r.b.re = sample_t'(longint'(a.re) - longint'(wb_re));
        r.b.im = sample_t'(longint'(a.im) - longint'(wb_im));
        return r;
endfunction

// Slot k of every lane uses the inputs seen during slot k
function automatic void model_frame(input complex_t slot_in [4][FRAME_SIZE],
                                    output complex_t frame_out [FRAME_SIZE]);
        lane_pair_t r;
        int         base;
        for (int lane = 0; lane < NUM_LANES; lane++)
        begin
                base = lane * LANE_SIZE;
                for (int k = 0; k < 4; k++)
                begin
                        r = model_butterfly(slot_in[k][base + k],
                                            slot_in[k][base + k + LANE_SIZE / 2],
                                            model_twiddle(k));
                        frame_out[base + k] = r.a;
                        frame_out[base + k + LANE_SIZE / 2] = r.b;
                end
        end
endfunction

`endif

//--- bench/fft_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fft_stage_tb import fft_pkg::*;
();

        localparam int NUM_LANES       = 4;
        localparam int LANE_SIZE       = 8;
        localparam int FRAME_SIZE      = NUM_LANES * LANE_SIZE;
        localparam int CLK_PERIOD      = 40;
        localparam int RESET_CYCLES    = 8;
        localparam int FRAMES_PER_TEST = 16;
        localparam int NUM_TESTS       = 5;
        localparam int WATCHDOG_CYCLES = FRAMES_PER_TEST * 4 * NUM_TESTS + 100;

        localparam int MODE_HELD     = 0;
        localparam int MODE_CHANGING = 1;
        localparam int MODE_EXTREME  = 2;

        logic     clk;
        logic     reset;
        complex_t samples_in  [FRAME_SIZE];
        complex_t samples_out [FRAME_SIZE];
        logic     frame_done;

        logic [31:0] rng_state;
        complex_t    next_in  [FRAME_SIZE];
        complex_t    hist     [4][FRAME_SIZE];
        complex_t    expected [FRAME_SIZE];
        int          pending_slot;
        int          pulse_count;
        int          check_count;
        int          error_count;

        `include "fft_model.svh"

        fft_stage_top #(
                .NUM_LANES (NUM_LANES)
        ) u_fft_stage_top (
                .clk         (clk),
                .reset       (reset),
                .samples_in  (samples_in),
                .samples_out (samples_out),
                .frame_done  (frame_done)
        );

        always #(CLK_PERIOD / 2) clk = ~clk;

        // xorshift32
        function automatic logic [31:0] next_random();
                logic [31:0] x;
                x = rng_state;
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                rng_state = x;
                return x;
        endfunction

        function automatic complex_t random_sample();
                logic [31:0] r;
                complex_t    s;
                r = next_random();
                s.re = sample_t'(r[15:0]);
                s.im = sample_t'(r[31:16]);
                return s;
        endfunction

        function automatic sample_t extreme_value(input logic [2:0] sel);
                sample_t v;
                case (sel)
                        3'd0:    v = -16'sd16384;
                        3'd1:    v = 16'sd16383;
                        3'd2:    v = 16'sh8000;
                        3'd3:    v = 16'sh7fff;
                        3'd4:    v = 16'sd16384;
                        3'd5:    v = -16'sd1;
                        3'd6:    v = 16'sd0;
                        default: v = 16'sd1;
                endcase
                return v;
        endfunction

        function automatic complex_t extreme_sample();
                logic [31:0] r;
                complex_t    s;
                r = next_random();
                s.re = extreme_value(r[2:0]);
                s.im = extreme_value(r[10:8]);
                return s;
        endfunction

        // Held mode draws a new frame only at slot 0
        task automatic drive_inputs(input int mode, input int slot_new);
                for (int i = 0; i < FRAME_SIZE; i++)
                begin
                        if (mode == MODE_EXTREME)
                                next_in[i] = extreme_sample();
                        else if (mode == MODE_CHANGING || slot_new == 0)
                                next_in[i] = random_sample();
                        samples_in[i] <= next_in[i];
                        hist[slot_new][i] = next_in[i];
                end
                pending_slot = slot_new;
        endtask

        task automatic check_reset_state();
                check_count++;
                assert (frame_done === 1'b0)
                else
                begin
                        $display("error at %0t: frame_done is %b during reset", $time, frame_done);
                        error_count++;
                end
                for (int i = 0; i < FRAME_SIZE; i++)
                begin
                        check_count++;
                        assert (samples_out[i] === '0)
                        else
                        begin
                                $display("error at %0t: samples_out[%0d] is %h, expected zero",
                                         $time, i, samples_out[i]);
                                error_count++;
                        end
                end
        endtask

        task automatic run_cycle(input int mode);
                int   loaded;
                logic expect_done;
                @(posedge clk);
                loaded = pending_slot;
                expect_done = (loaded == 3);
                if (expect_done)
                        model_frame(hist, expected);
                drive_inputs(mode, (loaded + 1) % 4);
                @(negedge clk);
                if (frame_done === 1'b1)
                        pulse_count++;
                check_count++;
                assert (frame_done === expect_done)
                else
                begin
                        $display("error at %0t: frame_done is %b, expected %b",
                                 $time, frame_done, expect_done);
                        error_count++;
                end
                if (expect_done)
                begin
                        for (int i = 0; i < FRAME_SIZE; i++)
                        begin
                                check_count++;
                                assert (samples_out[i] === expected[i])
                                else
                                begin
                                        $display("error at %0t: samples_out[%0d] is %h, expected %h",
                                                 $time, i, samples_out[i], expected[i]);
                                        error_count++;
                                end
                        end
                end
        endtask

        task automatic run_reset_test();
                int errors_before;
                errors_before = error_count;
                for (int c = 0; c < RESET_CYCLES; c++)
                begin
                        @(posedge clk);
                        if (c == RESET_CYCLES - 1)
                        begin
                                reset <= 1'b0;
                                drive_inputs(MODE_CHANGING, 0);
                        end
                        else
                        begin
                                for (int i = 0; i < FRAME_SIZE; i++)
                                        samples_in[i] <= random_sample();
                        end
                        @(negedge clk);
                        check_reset_state();
                end
                $display("test reset: %0d cycles, %0d errors",
                         RESET_CYCLES, error_count - errors_before);
        endtask

        // Last cycle already drives slot 0 of the next test's first frame
        task automatic run_test(input string name, input int mode, input int next_mode);
                int errors_before;
                errors_before = error_count;
                pulse_count = 0;
                for (int c = 0; c < 4 * FRAMES_PER_TEST; c++)
                begin
                        if (c == 4 * FRAMES_PER_TEST - 1)
                                run_cycle(next_mode);
                        else
                                run_cycle(mode);
                end
                check_count++;
                assert (pulse_count == FRAMES_PER_TEST)
                else
                begin
                        $display("error at %0t: %0d frame_done pulses, expected %0d",
                                 $time, pulse_count, FRAMES_PER_TEST);
                        error_count++;
                end
                $display("test %s: %0d frames, %0d errors",
                         name, pulse_count, error_count - errors_before);
        endtask

        initial
        begin
                clk = 1'b0;
                reset = 1'b1;
                rng_state = 32'h897b5708;
                pending_slot = 0;
                pulse_count = 0;
                check_count = 0;
                error_count = 0;
                for (int i = 0; i < FRAME_SIZE; i++)
                begin
                        samples_in[i] = '0;
                        next_in[i] = '0;
                end
                run_reset_test();
                run_test("frame_cadence", MODE_CHANGING, MODE_HELD);
                run_test("held_frames", MODE_HELD, MODE_CHANGING);
                run_test("changing_inputs", MODE_CHANGING, MODE_EXTREME);
                run_test("twiddle_edges", MODE_EXTREME, MODE_EXTREME);
                $display("summary: %0d checks, %0d errors", check_count, error_count);
                if (error_count == 0)
                        $display("TESTBENCH PASSED");
                else
                        $display("TESTBENCH FAILED");
                $finish;
        end

        initial
        begin
                #(WATCHDOG_CYCLES * CLK_PERIOD);
                $display("timeout: run did not finish within %0d clock periods",
                         WATCHDOG_CYCLES);
                $display("TESTBENCH FAILED");
                $finish;
        end

endmodule

`default_nettype wire

//--- list.f
+incdir+bench
src/fft_pkg.sv
src/slot_sequencer.sv
src/operand_select.sv
src/butterfly_unit.sv
src/result_bank.sv
src/fft_stage_top.sv
bench/fft_stage_tb.sv
